// File: logic/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Data and address width.
`define XLEN 32

// Lanes fed by one instruction pair.
`define NUM_LANES 2

// First fetch address.
`define RESET_PC 32'h0000_0000

`endif

// File: logic/core_pkg.sv
`default_nettype none

package core_pkg;

  // ==================================================
  // Decoded instruction fields
  // ==================================================

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl
  } alu_op_t;

  typedef enum logic [1:0] {
    class_none,  // Unsupported, retires as a no-op.
    class_alu,
    class_store
  } instr_class_t;

  // ==================================================
  // RV32I encodings
  // ==================================================

  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_store  = 7'b0100011;

  localparam logic [2:0] funct3_add = 3'b000;  // Also SUB.
  localparam logic [2:0] funct3_sll = 3'b001;
  localparam logic [2:0] funct3_sw  = 3'b010;
  localparam logic [2:0] funct3_xor = 3'b100;
  localparam logic [2:0] funct3_srl = 3'b101;
  localparam logic [2:0] funct3_or  = 3'b110;
  localparam logic [2:0] funct3_and = 3'b111;

  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000;

endpackage

`default_nettype wire

// File: logic/fetch_unit.sv
`default_nettype none
`timescale 1ns/1ps

`include "core_defs.svh"

module fetch_unit (
  input  logic              clock,
  input  logic              rst,
  input  logic [31:0]       imemory_rdata,
  input  logic              imemory_ready,
  input  logic              pair_done,
  output logic              imemory_valid,
  output logic [`XLEN-1:0]  imemory_addr,
  output logic              pair_strobe,
  output logic [31:0]       instr0,
  output logic [31:0]       instr1
);

  typedef enum logic [1:0] {
    st_word0,
    st_word1,
    st_wait
  } state_t;

  state_t           state;
  logic [`XLEN-1:0] pc;
  logic             accept;

  assign accept       = imemory_valid && imemory_ready;
  assign imemory_addr = pc;

  always_ff @(posedge clock) begin
    if (rst) begin
      state         <= st_word0;
      pc            <= `RESET_PC;
      imemory_valid <= 1'b0;
      pair_strobe   <= 1'b0;
    end else begin
      pair_strobe <= 1'b0;
      case (state)
        st_word0: begin
          imemory_valid <= 1'b1;  // First request after reset.
          if (accept) begin
            pc    <= pc + `XLEN'd4;
            state <= st_word1;
          end
        end
        st_word1: begin
          if (accept) begin
            pc            <= pc + `XLEN'd4;
            imemory_valid <= 1'b0;
            pair_strobe   <= 1'b1;
            state         <= st_wait;
          end
        end
        default: begin
          if (pair_done) begin
            imemory_valid <= 1'b1;
            state         <= st_word0;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept && state == st_word0) begin
      instr0 <= imemory_rdata;
    end
    if (accept && state == st_word1) begin
      instr1 <= imemory_rdata;
    end
  end

  // Issue closes only a pair that has been handed over.
  assert property (@(posedge clock) disable iff (rst) pair_done |-> state == st_wait);

endmodule

`default_nettype wire

// File: logic/issue_unit.sv
`default_nettype none
`timescale 1ns/1ps

`include "core_defs.svh"

module issue_unit (
  input  logic                   clock,
  input  logic                   rst,
  input  logic                   pair_strobe,
  input  logic [31:0]            instr0,
  input  logic [31:0]            instr1,
  input  logic                   retire_busy,
  input  logic [`XLEN-1:0]       rs_data [4],
  output logic                   pair_done,
  output logic [4:0]             rs_addr [4],
  output logic [`NUM_LANES-1:0]  issue_strobe,
  output core_pkg::instr_class_t lane_class [`NUM_LANES],
  output core_pkg::alu_op_t      lane_op [`NUM_LANES],
  output logic [`XLEN-1:0]       operand_a [`NUM_LANES],
  output logic [`XLEN-1:0]       operand_b [`NUM_LANES],
  output logic [4:0]             lane_rd [`NUM_LANES],
  output logic [`XLEN-1:0]       store_data [`NUM_LANES]
);

  logic [31:0]            slot_instr [`NUM_LANES];
  core_pkg::instr_class_t slot_class [`NUM_LANES];
  core_pkg::alu_op_t      slot_op [`NUM_LANES];
  logic [`NUM_LANES-1:0]  pending;
  logic                   blocked;
  logic                   issue_open;
  logic                   slot0_writes;
  logic                   reads_rs2;
  logic                   dependent;

  function automatic void decode_slot(
    input  logic [31:0]            instr,
    output core_pkg::instr_class_t cls,
    output core_pkg::alu_op_t      op
  );
    logic [2:0] funct3;
    logic [6:0] funct7;
    funct3 = instr[14:12];
    funct7 = instr[31:25];
    cls    = core_pkg::class_none;
    op     = core_pkg::alu_add;
    case (instr[6:0])
      core_pkg::opcode_op_imm: begin
        cls = core_pkg::class_alu;
        case (funct3)
          core_pkg::funct3_add: op = core_pkg::alu_add;
          core_pkg::funct3_xor: op = core_pkg::alu_xor;
          core_pkg::funct3_or:  op = core_pkg::alu_or;
          core_pkg::funct3_and: op = core_pkg::alu_and;
          default:              cls = core_pkg::class_none;  // Shifts by immediate.
        endcase
      end
      core_pkg::opcode_op: begin
        cls = core_pkg::class_alu;
        case (funct3)
          core_pkg::funct3_add: begin
            op = (funct7 == core_pkg::funct7_alt) ? core_pkg::alu_sub : core_pkg::alu_add;
          end
          core_pkg::funct3_sll: op = core_pkg::alu_sll;
          core_pkg::funct3_xor: op = core_pkg::alu_xor;
          core_pkg::funct3_srl: op = core_pkg::alu_srl;
          core_pkg::funct3_or:  op = core_pkg::alu_or;
          core_pkg::funct3_and: op = core_pkg::alu_and;
          default:              cls = core_pkg::class_none;
        endcase
        if (funct7 != core_pkg::funct7_base && op != core_pkg::alu_sub) begin
          cls = core_pkg::class_none;  // SRA and friends.
        end
      end
      core_pkg::opcode_store: begin
        if (funct3 == core_pkg::funct3_sw) begin
          cls = core_pkg::class_store;
        end
      end
      default: ;
    endcase
  endfunction

  // ==================================================
  // Decode and operand read
  // ==================================================

  always_comb begin
    for (int i = 0; i < `NUM_LANES; i++) begin
      decode_slot(slot_instr[i], slot_class[i], slot_op[i]);
      rs_addr[2*i]   = slot_instr[i][19:15];
      rs_addr[2*i+1] = slot_instr[i][24:20];
      lane_class[i]  = slot_class[i];
      lane_op[i]     = slot_op[i];
      lane_rd[i]     = slot_instr[i][11:7];
      operand_a[i]   = rs_data[2*i];
      store_data[i]  = rs_data[2*i+1];
      if (slot_class[i] == core_pkg::class_store) begin
        operand_b[i] = {{(`XLEN-12){slot_instr[i][31]}}, slot_instr[i][31:25],
                        slot_instr[i][11:7]};
      end else if (slot_instr[i][6:0] == core_pkg::opcode_op) begin
        operand_b[i] = rs_data[2*i+1];
      end else begin
        operand_b[i] = {{(`XLEN-12){slot_instr[i][31]}}, slot_instr[i][31:20]};
      end
    end
  end

  // ==================================================
  // Dependency check and issue windows
  // ==================================================

  assign slot0_writes = slot_class[0] == core_pkg::class_alu && lane_rd[0] != 5'd0;
  assign reads_rs2    = slot_class[1] == core_pkg::class_store ||
                        (slot_class[1] == core_pkg::class_alu &&
                         slot_instr[1][6:0] == core_pkg::opcode_op);
  assign dependent    = slot0_writes &&
                        ((slot_class[1] != core_pkg::class_none && rs_addr[2] == lane_rd[0]) ||
                         (reads_rs2 && rs_addr[3] == lane_rd[0]));

  assign issue_open      = !blocked && !retire_busy;
  assign issue_strobe[0] = pending[0] && issue_open;
  assign issue_strobe[1] = pending[1] && issue_open && !(pending[0] && dependent);

  always_ff @(posedge clock) begin
    if (rst) begin
      pending   <= '0;
      blocked   <= 1'b0;
      pair_done <= 1'b0;
    end else begin
      blocked   <= |issue_strobe;  // Closes the second cycle of the window.
      pair_done <= |issue_strobe && (pending & ~issue_strobe) == '0;
      if (pair_strobe) begin
        pending <= '1;
      end else begin
        pending <= pending & ~issue_strobe;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (pair_strobe) begin
      slot_instr[0] <= instr0;
      slot_instr[1] <= instr1;
    end
  end

  // A new pair never lands on slots still waiting to issue.
  assert property (@(posedge clock) disable iff (rst) pair_strobe |-> pending == '0);

endmodule

`default_nettype wire

// File: logic/exec_lane.sv
`default_nettype none
`timescale 1ns/1ps

`include "core_defs.svh"

module exec_lane (
  input  logic                   clock,
  input  logic                   rst,
  input  logic                   issue_strobe,
  input  core_pkg::instr_class_t lane_class,
  input  core_pkg::alu_op_t      lane_op,
  input  logic [`XLEN-1:0]       operand_a,
  input  logic [`XLEN-1:0]       operand_b,
  input  logic [4:0]             lane_rd,
  input  logic [`XLEN-1:0]       store_data,
  output logic                   result_strobe,
  output core_pkg::instr_class_t result_class,
  output logic [4:0]             result_rd,
  output logic [`XLEN-1:0]       result,
  output logic [`XLEN-1:0]       result_store_data
);

  logic [`XLEN-1:0] sum;
  logic [`XLEN-1:0] alu_value;
  logic [4:0]       shamt;

  assign sum   = operand_a + operand_b;
  assign shamt = operand_b[4:0];

  always_comb begin
    case (lane_op)
      core_pkg::alu_sub: alu_value = operand_a - operand_b;
      core_pkg::alu_and: alu_value = operand_a & operand_b;
      core_pkg::alu_or:  alu_value = operand_a | operand_b;
      core_pkg::alu_xor: alu_value = operand_a ^ operand_b;
      core_pkg::alu_sll: alu_value = operand_a << shamt;
      core_pkg::alu_srl: alu_value = operand_a >> shamt;
      default:           alu_value = sum;
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      result_strobe <= 1'b0;
    end else begin
      result_strobe <= issue_strobe;
    end
  end

  always_ff @(posedge clock) begin
    if (issue_strobe) begin
      result_class      <= lane_class;
      result_rd         <= lane_rd;
      result            <= (lane_class == core_pkg::class_store) ? sum : alu_value;  // Address.
      result_store_data <= store_data;
    end
  end

endmodule

`default_nettype wire

// File: logic/retire_unit.sv
`default_nettype none
`timescale 1ns/1ps

`include "core_defs.svh"

module retire_unit (
  input  logic                   clock,
  input  logic                   rst,
  input  logic [`NUM_LANES-1:0]  result_strobe,
  input  core_pkg::instr_class_t result_class [`NUM_LANES],
  input  logic [4:0]             result_rd [`NUM_LANES],
  input  logic [`XLEN-1:0]       result [`NUM_LANES],
  input  logic [`XLEN-1:0]       result_store_data [`NUM_LANES],
  input  logic [4:0]             rs_addr [4],
  input  logic                   dmemory_ready,
  output logic [`XLEN-1:0]       rs_data [4],
  output logic                   retire_busy,
  output logic                   dmemory_valid,
  output logic [`XLEN-1:0]       dmemory_addr,
  output logic [`XLEN-1:0]       dmemory_wdata,
  output logic [`XLEN/8-1:0]     dmemory_wstrb
);

  logic [`XLEN-1:0]      regs [32];
  logic [`NUM_LANES-1:0] store_in;
  logic [1:0]            st_valid;
  logic [`XLEN-1:0]      st_addr [2];
  logic [`XLEN-1:0]      st_data [2];
  logic                  st_accept;

  // ==================================================
  // Register file
  // ==================================================

  always_comb begin
    for (int k = 0; k < 4; k++) begin
      rs_data[k] = (rs_addr[k] == 5'd0) ? '0 : regs[rs_addr[k]];
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      for (int r = 0; r < 32; r++) begin
        regs[r] <= '0;
      end
    end else begin
      for (int i = 0; i < `NUM_LANES; i++) begin  // Later lane wins.
        if (result_strobe[i] && result_class[i] == core_pkg::class_alu &&
            result_rd[i] != 5'd0) begin
          regs[result_rd[i]] <= result[i];
        end
      end
    end
  end

  // ==================================================
  // Store queue
  // ==================================================

  always_comb begin
    for (int i = 0; i < `NUM_LANES; i++) begin
      store_in[i] = result_strobe[i] && result_class[i] == core_pkg::class_store;
    end
  end

  assign st_accept     = dmemory_valid && dmemory_ready;
  assign dmemory_valid = st_valid[0];
  assign dmemory_addr  = st_addr[0];
  assign dmemory_wdata = st_data[0];
  assign dmemory_wstrb = '1;

  always_ff @(posedge clock) begin
    if (rst) begin
      st_valid    <= 2'b00;
      retire_busy <= 1'b0;
    end else if (|store_in) begin
      st_valid    <= (&store_in) ? 2'b11 : 2'b01;  // Packed from the head.
      retire_busy <= 1'b1;
    end else if (st_accept) begin
      st_valid    <= {1'b0, st_valid[1]};
      retire_busy <= st_valid[1];
    end
  end

  always_ff @(posedge clock) begin
    if (|store_in) begin
      st_addr[0] <= store_in[0] ? result[0] : result[1];
      st_data[0] <= store_in[0] ? result_store_data[0] : result_store_data[1];
      st_addr[1] <= result[1];
      st_data[1] <= result_store_data[1];
    end else if (st_accept) begin
      st_addr[0] <= st_addr[1];
      st_data[0] <= st_data[1];
    end
  end

  // Issue must hold stores back until the queue has drained.
  assert property (@(posedge clock) disable iff (rst) |store_in |-> !retire_busy);

endmodule

`default_nettype wire

// File: logic/cpu.sv
`default_nettype none
`timescale 1ns/1ps

`include "core_defs.svh"

module cpu (
  input  logic              clock,
  input  logic              rst,
  output logic              imemory_valid,
  output logic [`XLEN-1:0]  imemory_addr,
  input  logic [31:0]       imemory_rdata,
  input  logic              imemory_ready,
  output logic              dmemory_valid,
  output logic [`XLEN-1:0]  dmemory_addr,
  output logic [`XLEN-1:0]  dmemory_wdata,
  output logic [`XLEN/8-1:0] dmemory_wstrb,
  input  logic              dmemory_ready
);

  logic                   pair_strobe;
  logic                   pair_done;
  logic [31:0]            instr0;
  logic [31:0]            instr1;
  logic [4:0]             rs_addr [4];
  logic [`XLEN-1:0]       rs_data [4];
  logic                   retire_busy;

  logic [`NUM_LANES-1:0]  issue_strobe;
  core_pkg::instr_class_t lane_class [`NUM_LANES];
  core_pkg::alu_op_t      lane_op [`NUM_LANES];
  logic [`XLEN-1:0]       operand_a [`NUM_LANES];
  logic [`XLEN-1:0]       operand_b [`NUM_LANES];
  logic [4:0]             lane_rd [`NUM_LANES];
  logic [`XLEN-1:0]       store_data [`NUM_LANES];

  logic [`NUM_LANES-1:0]  result_strobe;
  core_pkg::instr_class_t result_class [`NUM_LANES];
  logic [4:0]             result_rd [`NUM_LANES];
  logic [`XLEN-1:0]       result [`NUM_LANES];
  logic [`XLEN-1:0]       result_store_data [`NUM_LANES];

  fetch_unit u_fetch (
    .clock         (clock),
    .rst           (rst),
    .imemory_rdata (imemory_rdata),
    .imemory_ready (imemory_ready),
    .pair_done     (pair_done),
    .imemory_valid (imemory_valid),
    .imemory_addr  (imemory_addr),
    .pair_strobe   (pair_strobe),
    .instr0        (instr0),
    .instr1        (instr1)
  );

  issue_unit u_issue (
    .clock        (clock),
    .rst          (rst),
    .pair_strobe  (pair_strobe),
    .instr0       (instr0),
    .instr1       (instr1),
    .retire_busy  (retire_busy),
    .rs_data      (rs_data),
    .pair_done    (pair_done),
    .rs_addr      (rs_addr),
    .issue_strobe (issue_strobe),
    .lane_class   (lane_class),
    .lane_op      (lane_op),
    .operand_a    (operand_a),
    .operand_b    (operand_b),
    .lane_rd      (lane_rd),
    .store_data   (store_data)
  );

  // ==================================================
  // Execution lanes
  // ==================================================

  for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
    exec_lane u_lane (
      .clock             (clock),
      .rst               (rst),
      .issue_strobe      (issue_strobe[i]),
      .lane_class        (lane_class[i]),
      .lane_op           (lane_op[i]),
      .operand_a         (operand_a[i]),
      .operand_b         (operand_b[i]),
      .lane_rd           (lane_rd[i]),
      .store_data        (store_data[i]),
      .result_strobe     (result_strobe[i]),
      .result_class      (result_class[i]),
      .result_rd         (result_rd[i]),
      .result            (result[i]),
      .result_store_data (result_store_data[i])
    );
  end

  retire_unit u_retire (
    .clock             (clock),
    .rst               (rst),
    .result_strobe     (result_strobe),
    .result_class      (result_class),
    .result_rd         (result_rd),
    .result            (result),
    .result_store_data (result_store_data),
    .rs_addr           (rs_addr),
    .dmemory_ready     (dmemory_ready),
    .rs_data           (rs_data),
    .retire_busy       (retire_busy),
    .dmemory_valid     (dmemory_valid),
    .dmemory_addr      (dmemory_addr),
    .dmemory_wdata     (dmemory_wdata),
    .dmemory_wstrb     (dmemory_wstrb)
  );

endmodule

`default_nettype wire

// File: test/cpu_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "core_defs.svh"

module cpu_tb;

  localparam logic [31:0] nop_word = 32'h0000_0013;  // ADDI x0, x0, 0.

  logic                clock = 1'b0;
  logic                rst = 1'b1;
  logic                imemory_valid;
  logic [`XLEN-1:0]    imemory_addr;
  logic [31:0]         imemory_rdata = '0;
  logic                imemory_ready = 1'b0;
  logic                dmemory_valid;
  logic [`XLEN-1:0]    dmemory_addr;
  logic [`XLEN-1:0]    dmemory_wdata;
  logic [`XLEN/8-1:0]  dmemory_wstrb;
  logic                dmemory_ready = 1'b0;

  logic [31:0]         prog [$];
  logic [31:0]         exp_addr [$];
  logic [31:0]         exp_data [$];
  int                  store_count;
  logic [31:0]         next_fetch;
  int unsigned         imem_stall;
  int unsigned         dmem_stall;
  int                  cycles;

  cpu u_cpu (
    .clock         (clock),
    .rst           (rst),
    .imemory_valid (imemory_valid),
    .imemory_addr  (imemory_addr),
    .imemory_rdata (imemory_rdata),
    .imemory_ready (imemory_ready),
    .dmemory_valid (dmemory_valid),
    .dmemory_addr  (dmemory_addr),
    .dmemory_wdata (dmemory_wdata),
    .dmemory_wstrb (dmemory_wstrb),
    .dmemory_ready (dmemory_ready)
  );

  always #5 clock = ~clock;

  task automatic stop_with_failure();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string test, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("error %s: expected %h, actual %h", test, expected, actual);
    stop_with_failure();
  endtask

  task automatic report_problem(input string what);
    $display("%s", what);
    stop_with_failure();
  endtask

  // ==================================================
  // Instruction encoding and program
  // ==================================================

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  task automatic build_program();
    prog.push_back(i_type(12'h123, 5'd0, 3'b000, 5'd1));  // Independent pair.
    prog.push_back(i_type(12'hfaa, 5'd0, 3'b000, 5'd2));
    prog.push_back(s_type(12'h100, 5'd1, 5'd0));  // Two stores in one pair.
    prog.push_back(s_type(12'h104, 5'd2, 5'd0));
    prog.push_back(i_type(12'h0f0, 5'd1, 3'b100, 5'd3));  // XORI.
    prog.push_back(i_type(12'h00f, 5'd2, 3'b110, 5'd4));  // ORI.
    prog.push_back(i_type(12'h0ff, 5'd1, 3'b111, 5'd5));  // ANDI.
    prog.push_back(s_type(12'h108, 5'd3, 5'd0));
    prog.push_back(s_type(12'h10c, 5'd4, 5'd0));
    prog.push_back(s_type(12'h110, 5'd5, 5'd0));
    prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd6));  // ADD.
    prog.push_back(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd7));  // SUB.
    prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd8));  // AND.
    prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd9));  // OR.
    prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd10));  // XOR.
    prog.push_back(i_type(12'h004, 5'd0, 3'b000, 5'd11));
    prog.push_back(r_type(7'h00, 5'd11, 5'd1, 3'b001, 5'd12));  // SLL.
    prog.push_back(r_type(7'h00, 5'd11, 5'd2, 3'b101, 5'd13));  // SRL of a negative value.
    prog.push_back(s_type(12'h114, 5'd6, 5'd0));
    prog.push_back(s_type(12'h118, 5'd7, 5'd0));
    prog.push_back(s_type(12'h11c, 5'd8, 5'd0));
    prog.push_back(s_type(12'h120, 5'd9, 5'd0));
    prog.push_back(s_type(12'h124, 5'd10, 5'd0));
    prog.push_back(s_type(12'h128, 5'd11, 5'd0));
    prog.push_back(s_type(12'h12c, 5'd12, 5'd0));
    prog.push_back(s_type(12'h130, 5'd13, 5'd0));
    prog.push_back(i_type(12'h007, 5'd1, 3'b000, 5'd14));  // Slot 1 reads x14 twice.
    prog.push_back(r_type(7'h00, 5'd14, 5'd14, 3'b000, 5'd15));
    prog.push_back(i_type(12'h001, 5'd0, 3'b000, 5'd16));  // Same rd, slot 1 wins.
    prog.push_back(i_type(12'h002, 5'd0, 3'b000, 5'd16));
    prog.push_back(i_type(12'h009, 5'd0, 3'b000, 5'd17));
    prog.push_back(s_type(12'h134, 5'd17, 5'd0));  // Store data from slot 0.
    prog.push_back(s_type(12'h138, 5'd15, 5'd0));
    prog.push_back(s_type(12'h13c, 5'd16, 5'd0));
    prog.push_back(i_type(12'h005, 5'd1, 3'b000, 5'd0));  // Writes to x0 from both lanes.
    prog.push_back(i_type(12'h003, 5'd2, 3'b000, 5'd0));
    prog.push_back(s_type(12'h140, 5'd0, 5'd0));  // Next pair reads x0.
  endtask

  // ==================================================
  // Golden model, in program order
  // ==================================================

  task automatic run_golden_model();
    logic [31:0] x [32];
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] value;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic        writes;
    for (int r = 0; r < 32; r++) begin
      x[r] = '0;
    end
    foreach (prog[n]) begin
      w      = prog[n];
      a      = x[w[19:15]];
      b      = x[w[24:20]];
      imm_i  = {{20{w[31]}}, w[31:20]};
      imm_s  = {{20{w[31]}}, w[31:25], w[11:7]};
      writes = 1'b1;
      value  = '0;
      case (w[6:0])
        7'b0010011: begin
          case (w[14:12])
            3'b000:  value = a + imm_i;
            3'b100:  value = a ^ imm_i;
            3'b110:  value = a | imm_i;
            3'b111:  value = a & imm_i;
            default: writes = 1'b0;
          endcase
        end
        7'b0110011: begin
          case ({w[31:25], w[14:12]})
            10'b0000000_000: value = a + b;
            10'b0100000_000: value = a - b;
            10'b0000000_001: value = a << b[4:0];
            10'b0000000_100: value = a ^ b;
            10'b0000000_101: value = a >> b[4:0];
            10'b0000000_110: value = a | b;
            10'b0000000_111: value = a & b;
            default:         writes = 1'b0;
          endcase
        end
        7'b0100011: begin
          writes = 1'b0;
          if (w[14:12] == 3'b010) begin
            exp_addr.push_back(a + imm_s);
            exp_data.push_back(b);
          end
        end
        default: writes = 1'b0;
      endcase
      if (writes && w[11:7] != 5'd0) begin
        x[w[11:7]] = value;
      end
    end
  endtask

  // ==================================================
  // Memory models
  // ==================================================

  always @(negedge clock) begin : drive_imem
    int idx;
    idx = int'(imemory_addr >> 2);
    if (rst || idx >= prog.size()) begin
      imemory_rdata <= nop_word;
    end else begin
      imemory_rdata <= prog[idx];
    end
    if (imem_stall != 0) begin
      imemory_ready <= 1'b0;
      imem_stall    <= imem_stall - 1;
    end else begin
      imemory_ready <= 1'b1;
      imem_stall    <= $urandom % 4;  // Next stall, 0 to 3 cycles.
    end
  end

  always @(negedge clock) begin
    if (dmem_stall != 0) begin
      dmemory_ready <= 1'b0;
      dmem_stall    <= dmem_stall - 1;
    end else begin
      dmemory_ready <= 1'b1;
      dmem_stall    <= $urandom % 4;
    end
  end

  // ==================================================
  // Checks
  // ==================================================

  always @(posedge clock) begin
    if (rst) begin
      next_fetch  <= `RESET_PC;
      store_count <= 0;
    end else begin
      if (imemory_valid && imemory_ready) begin
        assert (imemory_addr == next_fetch)
          else report_mismatch("fetch address", next_fetch, imemory_addr);
        next_fetch <= next_fetch + 32'd4;
      end
      if (dmemory_valid && dmemory_ready) begin
        if (store_count >= exp_addr.size()) begin
          report_problem("a store arrived after all expected stores were seen");
        end else begin
          assert (dmemory_addr == exp_addr[store_count])
            else report_mismatch($sformatf("store %0d address", store_count),
                                 exp_addr[store_count], dmemory_addr);
          assert (dmemory_wdata == exp_data[store_count])
            else report_mismatch($sformatf("store %0d data", store_count),
                                 exp_data[store_count], dmemory_wdata);
          store_count <= store_count + 1;
        end
      end
    end
  end

  assert property (@(posedge clock) rst |=> !dmemory_valid)
    else report_problem("data request seen during or right after reset");

  assert property (@(posedge clock) disable iff (rst)
    imemory_valid && !imemory_ready |=> imemory_valid && $stable(imemory_addr))
    else report_problem("instruction request dropped or moved while stalled");

  assert property (@(posedge clock) disable iff (rst)
    dmemory_valid && !dmemory_ready |=>
      dmemory_valid && $stable(dmemory_addr) && $stable(dmemory_wdata))
    else report_problem("store request dropped or changed while stalled");

  assert property (@(posedge clock) disable iff (rst) dmemory_valid |-> &dmemory_wstrb)
    else report_mismatch("store strobe", 32'hf, {28'd0, dmemory_wstrb});

  initial begin
    void'($urandom(55));
    build_program();
    run_golden_model();
    repeat (5) @(posedge clock);
    @(negedge clock);
    rst    = 1'b0;
    cycles = 0;
    while (store_count < exp_addr.size() && cycles < 4000) begin
      @(posedge clock);
      cycles++;
    end
    if (store_count < exp_addr.size()) begin
      report_problem("timed out waiting for the expected stores");
    end else begin
      repeat (20) @(posedge clock);  // Catches any extra store.
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+logic
logic/core_pkg.sv
logic/fetch_unit.sv
logic/issue_unit.sv
logic/exec_lane.sv
logic/retire_unit.sv
logic/cpu.sv
test/cpu_tb.sv

// File: Makefile
SOURCES := $(shell grep -v '^+' all.f)

.PHONY: run clean

run: obj_dir/Vcpu_tb
	./obj_dir/Vcpu_tb | tee /dev/stderr | grep -qx "Testbench passed"

obj_dir/Vcpu_tb: all.f $(SOURCES) logic/core_defs.svh
	verilator --binary --timing --assert --top-module cpu_tb -f all.f

clean:
	rm -rf obj_dir
